//--- rtl/svm_pkg.sv
/* Shared types and fixed-point constants for the scalar-by-vector multiplier.
   Imported by every RTL module and by the verification components. */

`default_nettype none

package svm_pkg;

    // width of one Q8.8 operand and of the full signed product.
    localparam int Q88_W  = 16;
    localparam int PROD_W = 2 * Q88_W;

    // a Q8.8 value has 8 fraction bits, so the product of two carries 16.
    localparam int FRAC_BITS = 8;

    // operand register, product register and output register in each lane.
    localparam int MULT_LATENCY = 3;

    // signed Q8.8 value, used for the scalar and for every vector element.
    typedef logic signed [Q88_W-1:0] q88_t;

    // signed full-width product with 2*FRAC_BITS fraction bits.
    typedef logic signed [PROD_W-1:0] prod_t;

    // one copy of the registered scalar, sent to one group of lanes.
    typedef struct packed {
        logic valid;
        q88_t data;
    } scalar_bcast_t;

endpackage

`default_nettype wire

//--- rtl/scalar_broadcast.sv
/* Registers the scalar strobe and data into one independent copy per lane group,
   so that each copy only drives GROUP_SIZE multipliers. */

`default_nettype none

module scalar_broadcast #(
    parameter int LANES      = 64,
    parameter int GROUP_SIZE = 8
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  sig_v,
    input  svm_pkg::q88_t                                         sig_data,
    output svm_pkg::scalar_bcast_t [LANES/GROUP_SIZE-1:0]         bcast
);

    import svm_pkg::*;

    localparam int GROUPS = LANES / GROUP_SIZE;

    // every group gets its own flops; the keep attribute stops synthesis
    // from merging the identical copies back into a single high-fanout register.
    for (genvar g = 0; g < GROUPS; g++) begin : g_copy
        (* keep = "true" *) logic valid_q;
        (* keep = "true" *) q88_t data_q;

        always_ff @(posedge clk) begin
            if (!rst) begin
                valid_q <= 1'b0;
            end else begin
                valid_q <= sig_v;
            end
        end

        // the data only needs to change when a new scalar arrives.
        always_ff @(posedge clk) begin
            if (sig_v) begin
                data_q <= sig_data;
            end
        end

        assign bcast[g].valid = valid_q;
        assign bcast[g].data  = data_q;
    end

endmodule

`default_nettype wire

//--- rtl/lane_multiplier.sv
/* Three-stage pipelined signed 16x16 multiplier for one vector lane.
   Every stage advances only while the clock enable of its lane group is high. */

`default_nettype none

module lane_multiplier (
    input  logic           clk,
    input  logic           ce,
    input  svm_pkg::q88_t  a,
    input  svm_pkg::q88_t  b,
    output svm_pkg::prod_t p
);

    import svm_pkg::*;

    // stage 1 operand registers.
    q88_t  a_q;
    q88_t  b_q;

    // stage 2 product register.
    prod_t mult_q;

    // stage 3 output register.
    prod_t p_q;

    always_ff @(posedge clk) begin
        if (ce) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // both operands are signed, so the 32-bit product is sign correct.
    always_ff @(posedge clk) begin
        if (ce) begin
            mult_q <= a_q * b_q;
        end
    end

    always_ff @(posedge clk) begin
        if (ce) begin
            p_q <= mult_q;
        end
    end

    assign p = p_q;

endmodule

`default_nettype wire

//--- rtl/mult_array.sv
/* Builds one pipelined multiplier per lane, follows each item through the
   pipeline with a valid shift register and drives the per-group clock enables. */

`default_nettype none

module mult_array #(
    parameter int LANES      = 64,
    parameter int GROUP_SIZE = 8
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  svm_pkg::scalar_bcast_t [LANES/GROUP_SIZE-1:0] bcast,
    input  svm_pkg::q88_t [LANES-1:0]                     vec_data,
    output svm_pkg::prod_t [LANES-1:0]                    prod,
    output logic                                          prod_v
);

    import svm_pkg::*;

    localparam int GROUPS = LANES / GROUP_SIZE;

    // bit n is set when an item sits in pipeline stage n+1 of the lanes.
    logic [MULT_LATENCY-1:0] vld_q;

    // true while an item still has to move into a later stage.
    logic                    in_flight;

    logic [GROUPS-1:0]       grp_ce;

    // all broadcast copies carry the same strobe, so copy 0 feeds the tracker.
    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MULT_LATENCY-2:0], bcast[0].valid};
        end
    end

    // an item in the last stage is already at the output and needs no enable.
    assign in_flight = |vld_q[MULT_LATENCY-2:0];

    assign prod_v = vld_q[MULT_LATENCY-1];

    // a group only clocks its multipliers while it has work, otherwise it idles.
    for (genvar g = 0; g < GROUPS; g++) begin : g_ce
        assign grp_ce[g] = bcast[g].valid | in_flight;
    end

    // lane i takes the scalar from the copy of its own group.
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lane_multiplier i_lane_multiplier (
            .clk (clk),
            .ce  (grp_ce[i / GROUP_SIZE]),
            .a   (bcast[i / GROUP_SIZE].data),
            .b   (vec_data[i]),
            .p   (prod[i])
        );
    end

endmodule

`default_nettype wire

//--- rtl/result_capture.sv
/* Cuts every lane product back to Q8.8 and holds the result vector until the
   next product arrives; res_v is the product strobe one register later. */

`default_nettype none

module result_capture #(
    parameter int LANES = 64
) (
    input  logic                       clk,
    input  logic                       rst,
    input  svm_pkg::prod_t [LANES-1:0] prod,
    input  logic                       prod_v,
    output logic                       res_v,
    output svm_pkg::q88_t [LANES-1:0]  res_data
);

    import svm_pkg::*;

    // the Q8.8 result sits in product bits FRAC_BITS+15 down to FRAC_BITS.
    localparam int CUT_LSB = FRAC_BITS;
    localparam int CUT_MSB = FRAC_BITS + Q88_W - 1;

    q88_t [LANES-1:0] cut;

    // plain truncation; bits above the Q8.8 range are dropped without saturation.
    for (genvar i = 0; i < LANES; i++) begin : g_cut
        assign cut[i] = prod[i][CUT_MSB:CUT_LSB];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            res_v <= 1'b0;
        end else begin
            res_v <= prod_v;
        end
    end

    // the last result stays visible while later items are still in the pipeline.
    always_ff @(posedge clk) begin
        if (!rst) begin
            res_data <= '0;
        end else if (prod_v) begin
            res_data <= cut;
        end
    end

endmodule

`default_nettype wire

//--- rtl/scalar_vector_mult.sv
/* Top level of the Q8.8 scalar-by-vector multiplier. A scalar strobed with sig_v
   is multiplied by vec_data of the next cycle; res_v follows five cycles later. */

`default_nettype none

module scalar_vector_mult #(
    parameter int LANES      = 64,
    parameter int GROUP_SIZE = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sig_v,
    input  svm_pkg::q88_t             sig_data,
    input  svm_pkg::q88_t [LANES-1:0] vec_data,
    output logic                      res_v,
    output svm_pkg::q88_t [LANES-1:0] res_data
);

    import svm_pkg::*;

    localparam int GROUPS = LANES / GROUP_SIZE;

    // lanes are split into whole groups only.
    if (GROUPS * GROUP_SIZE != LANES) begin : g_bad_group
        $error("LANES must be a multiple of GROUP_SIZE");
    end

    scalar_bcast_t [GROUPS-1:0] bcast;
    prod_t [LANES-1:0]          prod;
    logic                       prod_v;

    scalar_broadcast #(
        .LANES      (LANES),
        .GROUP_SIZE (GROUP_SIZE)
    ) i_scalar_broadcast (
        .clk      (clk),
        .rst      (rst),
        .sig_v    (sig_v),
        .sig_data (sig_data),
        .bcast    (bcast)
    );

    mult_array #(
        .LANES      (LANES),
        .GROUP_SIZE (GROUP_SIZE)
    ) i_mult_array (
        .clk      (clk),
        .rst      (rst),
        .bcast    (bcast),
        .vec_data (vec_data),
        .prod     (prod),
        .prod_v   (prod_v)
    );

    result_capture #(
        .LANES (LANES)
    ) i_result_capture (
        .clk      (clk),
        .rst      (rst),
        .prod     (prod),
        .prod_v   (prod_v),
        .res_v    (res_v),
        .res_data (res_data)
    );

endmodule

`default_nettype wire

//--- testbench/scalar_vector_mult_checker.sv
/* Timing assertions on the multiplier's top-level ports.
   Bound into the top level from the testbench. */

`default_nettype none

module scalar_vector_mult_checker #(
    parameter int LANES = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sig_v,
    input  logic                      res_v,
    input  svm_pkg::q88_t [LANES-1:0] res_data
);

    import svm_pkg::*;

    int fail_count = 0;

    // the result strobe clears on the first reset edge.
    res_v_low_in_reset: assert property (@(posedge clk) !rst |=> !res_v)
        else begin
            $error("res_v still high one cycle into reset");
            fail_count++;
        end

    // every scalar strobe gives exactly one result strobe, five cycles later.
    res_v_follows_sig_v: assert property (@(posedge clk) disable iff (!rst)
        res_v == $past(sig_v, 5))
        else begin
            $error("res_v does not follow sig_v by five cycles");
            fail_count++;
        end

    res_data_held: assert property (@(posedge clk) disable iff (!rst)
        !res_v |-> $stable(res_data))
        else begin
            $error("res_data changed while res_v was low");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- testbench/result_monitor.sv
/* Watches the multiplier outputs and compares every result with the expected
   truncated Q8.8 products of the queued scalar and vector. */

`default_nettype none

module result_monitor #(
    parameter int LANES = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      res_v,
    input  svm_pkg::q88_t [LANES-1:0] res_data
);

    import svm_pkg::*;

    q88_t             scalar_q [$];
    q88_t [LANES-1:0] vec_q [$];
    q88_t             exp_scalar;
    q88_t [LANES-1:0] exp_vec;
    q88_t             exp_lane;
    logic             seen_result = 1'b0;
    int               error_count = 0;
    int               result_count = 0;

    // full signed product, then bits 23 down to 8 with the high bits dropped.
    function automatic q88_t expected_lane(input q88_t scalar, input q88_t elem);
        logic signed [31:0] full;
        full = 32'(scalar) * 32'(elem);
        return full[23:8];
    endfunction

    task automatic expect_result(input q88_t scalar, input q88_t [LANES-1:0] vec);
        scalar_q.push_back(scalar);
        vec_q.push_back(vec);
    endtask

    always @(posedge clk) begin : sample
        int lane;
        if (rst && res_v) begin
            if (scalar_q.size() == 0) begin
                $display("ERROR t=%0t: res_v high but no result was expected", $time);
                error_count++;
            end else begin
                exp_scalar = scalar_q.pop_front();
                exp_vec = vec_q.pop_front();
                for (lane = 0; lane < LANES; lane++) begin
                    exp_lane = expected_lane(exp_scalar, exp_vec[lane]);
                    if (res_data[lane] !== exp_lane) begin
                        $display("CHECK FAILED t=%0t res_data[%0d]: expected %h, actual %h",
                                 $time, lane, exp_lane, res_data[lane]);
                        error_count++;
                    end
                end
                result_count++;
                seen_result = 1'b1;
            end
        end else if (rst && !seen_result) begin
            for (lane = 0; lane < LANES; lane++) begin
                if (res_data[lane] !== '0) begin
                    $display("CHECK FAILED t=%0t res_data[%0d]: expected %h, actual %h",
                             $time, lane, 16'h0000, res_data[lane]);
                    error_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_scalar_vector_mult.sv
/* Testbench for the scalar-by-vector multiplier. Applies a table of scalars and
   vector patterns, with idle gaps, and reports the totals at the end. */

`default_nettype none

module tb_scalar_vector_mult;

    import svm_pkg::*;

    localparam int LANES          = 64;
    localparam int GROUP_SIZE     = 8;
    localparam int SEED           = 59665;
    localparam int RESULT_TIMEOUT = 50;
    localparam int NUM_STIM       = 16;

    localparam logic [2:0] PAT_ZERO = 3'd0;
    localparam logic [2:0] PAT_ONES = 3'd1;
    localparam logic [2:0] PAT_RAMP = 3'd2;
    localparam logic [2:0] PAT_RAND = 3'd3;
    localparam logic [2:0] PAT_ALT  = 3'd4;

    typedef q88_t [LANES-1:0] vec_t;

    typedef struct packed {
        q88_t       scalar;
        logic [2:0] pattern;
        logic [3:0] gap;
    } stim_t;

    // entries 3 to 7, 9 to 10, 11 to 12 and 13 to 15 arrive on consecutive cycles.
    stim_t stim_table [NUM_STIM] = '{
        '{16'sh0100, PAT_RAMP, 4'd2},
        '{16'shFF00, PAT_RAMP, 4'd1},
        '{16'sh0000, PAT_RAND, 4'd1},
        '{16'sh0180, PAT_ZERO, 4'd0},
        '{16'sh7FFF, PAT_ONES, 4'd0},
        '{16'sh8000, PAT_ALT,  4'd0},
        '{16'shFE40, PAT_RAND, 4'd0},
        '{16'sh0080, PAT_ALT,  4'd4},
        '{16'sh1234, PAT_RAMP, 4'd3},
        '{16'shC000, PAT_ALT,  4'd0},
        '{16'sh0001, PAT_RAND, 4'd2},
        '{16'shFFFF, PAT_RAND, 4'd0},
        '{16'sh2A00, PAT_ONES, 4'd6},
        '{16'sh0A55, PAT_RAND, 4'd0},
        '{16'shF3C0, PAT_RAMP, 4'd0},
        '{16'sh0300, PAT_ALT,  4'd2}
    };

    logic clk = 1'b0;
    logic rst;
    logic sig_v;
    q88_t sig_data;
    vec_t vec_data;
    logic res_v;
    vec_t res_data;

    vec_t pend_vec;
    logic have_pending;
    logic timed_out;
    int   total_errors;

    always #2 clk = ~clk;

    scalar_vector_mult #(
        .LANES      (LANES),
        .GROUP_SIZE (GROUP_SIZE)
    ) i_scalar_vector_mult (
        .clk      (clk),
        .rst      (rst),
        .sig_v    (sig_v),
        .sig_data (sig_data),
        .vec_data (vec_data),
        .res_v    (res_v),
        .res_data (res_data)
    );

    result_monitor #(
        .LANES (LANES)
    ) i_result_monitor (
        .clk      (clk),
        .rst      (rst),
        .res_v    (res_v),
        .res_data (res_data)
    );

    bind scalar_vector_mult scalar_vector_mult_checker #(.LANES(LANES)) i_checker (
        .clk      (clk),
        .rst      (rst),
        .sig_v    (sig_v),
        .res_v    (res_v),
        .res_data (res_data)
    );

    function automatic vec_t build_vector(input logic [2:0] pattern);
        vec_t v;
        int   mag;
        for (int i = 0; i < LANES; i++) begin
            mag = 384 + i * 5;
            case (pattern)
                PAT_ZERO: v[i] = '0;
                PAT_ONES: v[i] = 16'sh0100;
                PAT_RAMP: v[i] = q88_t'((i - LANES / 2) * 97);
                PAT_RAND: v[i] = q88_t'($urandom);
                default:  v[i] = q88_t'((i % 2 == 1) ? -mag : mag);
            endcase
        end
        return v;
    endfunction

    // the vector of an entry goes out one cycle after its scalar strobe.
    // Idle cycles carry noise, which the DUT must ignore.
    task automatic drive_pending_vector();
        if (have_pending) begin
            vec_data = pend_vec;
            have_pending = 1'b0;
        end else begin
            vec_data = build_vector(PAT_RAND);
        end
    endtask

    initial begin : stimulus
        vec_t next_vec;
        int   wait_cycles;
        void'($urandom(SEED));
        rst = 1'b0;
        sig_v = 1'b0;
        sig_data = '0;
        vec_data = '0;
        have_pending = 1'b0;
        timed_out = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);

        for (int e = 0; e < NUM_STIM; e++) begin
            next_vec = build_vector(stim_table[e].pattern);
            @(negedge clk);
            drive_pending_vector();
            sig_v = 1'b1;
            sig_data = stim_table[e].scalar;
            i_result_monitor.expect_result(stim_table[e].scalar, next_vec);
            pend_vec = next_vec;
            have_pending = 1'b1;
            for (int g = 0; g < int'(stim_table[e].gap); g++) begin
                @(negedge clk);
                sig_v = 1'b0;
                drive_pending_vector();
            end
        end
        @(negedge clk);
        sig_v = 1'b0;
        drive_pending_vector();

        wait_cycles = 0;
        while (i_result_monitor.result_count < NUM_STIM && wait_cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (i_result_monitor.result_count < NUM_STIM) begin
            timed_out = 1'b1;
            $display("ERROR: timed out, results are missing: %0d of %0d arrived",
                     i_result_monitor.result_count, NUM_STIM);
        end

        // extra idle cycles so that a stray result strobe is still seen.
        repeat (8) @(negedge clk);

        total_errors = i_result_monitor.error_count
                     + i_scalar_vector_mult.i_checker.fail_count
                     + (timed_out ? 1 : 0);
        $display("errors: %0d (monitor %0d, assertions %0d), results: %0d of %0d",
                 total_errors, i_result_monitor.error_count,
                 i_scalar_vector_mult.i_checker.fail_count,
                 i_result_monitor.result_count, NUM_STIM);
        if (total_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- scalar_vector_mult.f
rtl/svm_pkg.sv
rtl/scalar_broadcast.sv
rtl/lane_multiplier.sv
rtl/mult_array.sv
rtl/result_capture.sv
rtl/scalar_vector_mult.sv
testbench/scalar_vector_mult_checker.sv
testbench/result_monitor.sv
testbench/tb_scalar_vector_mult.sv

//--- Makefile
# Verilator build and simulation of the scalar-by-vector multiplier.

BUILD_DIR := build
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_scalar_vector_mult -Mdir $(BUILD_DIR) \
		-f scalar_vector_mult.f
	./$(BUILD_DIR)/Vtb_scalar_vector_mult +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
